// File: logic/exec_pkg.sv
`default_nettype none

package exec_pkg;

	// alu operations, in decoder order.
	typedef enum logic [4:0] {
		ADD,
		ADDC,
		SUB,
		SUBC,
		LSL,
		LSR,
		ASR,
		AND,
		OR,
		XOR,
		BIC,
		BST,
		COPYA,
		COPYB,
		CMP,
		MOVHI,
		GCR,
		SWI,
		RFE
	} alu_opc_t;

	typedef enum logic [3:0] {
		NE   = 4'h1,
		EQ   = 4'h2,
		GT   = 4'h3,
		LT   = 4'h4,
		GTS  = 4'h5,
		LTS  = 4'h6,
		B    = 4'h7,
		GTE  = 4'h8,
		GTES = 4'h9,
		LTE  = 4'ha,
		LTES = 4'hb
	} branch_cc_t;

	typedef enum logic [1:0] {
		ARITH  = 2'd0,
		BRANCH = 2'd1,
		MEM    = 2'd2
	} instr_class_t;

	// indices 4 to 7 are unimplemented and read as zero.
	typedef enum logic [2:0] {
		CR_VBASE     = 3'd0,
		CR_PSR       = 3'd1,
		CR_SAVED_PSR = 3'd2,
		CR_FAULT     = 3'd3
	} cr_idx_t;

	//////////////////////////////
	// status word layout.
	localparam int PSR_W    = 6;
	localparam int PSR_Z    = 0;
	localparam int PSR_C    = 1;
	localparam int PSR_O    = 2;
	localparam int PSR_N    = 3;
	localparam int PSR_IRQ  = 4;
	localparam int PSR_USER = 5;

	localparam int SWI_OFFSET = 8; // handler offset from the vector base.

endpackage

`default_nettype wire

// File: logic/exec_alu.sv
`default_nettype none

module exec_alu import exec_pkg::*; (
	input  logic [31:0] i_op1,
	input  logic [31:0] i_op2,
	input  alu_opc_t    i_opc,
	input  logic        i_carry_in,
	input  logic [31:0] i_cr_val,
	input  logic [31:0] i_vector_base,
	input  logic [31:0] i_fault_addr,
	output logic [31:0] o_result,
	output logic        o_c,
	output logic        o_z,
	output logic        o_n,
	output logic        o_o
);

logic [32:0] sum;
logic [32:0] diff; // bit 32 is the borrow.

assign sum = {1'b0, i_op1} + {1'b0, i_op2};
assign diff = {1'b0, i_op1} - {1'b0, i_op2};

// z compares the operands directly, independent of the opcode.
assign o_z = (i_op1 == i_op2);

always_comb begin
	o_result = 32'b0;
	o_c = 1'b0;
	o_n = 1'b0;
	o_o = 1'b0;

	case (i_opc)
	ADD:   {o_c, o_result} = sum;
	ADDC:  {o_c, o_result} = sum + {32'b0, i_carry_in};
	SUB:   {o_c, o_result} = diff;
	SUBC:  {o_c, o_result} = diff - {32'b0, i_carry_in};
	LSL:   {o_c, o_result} = {1'b0, i_op1} << i_op2[4:0];
	LSR:   o_result = i_op1 >> i_op2[4:0];
	ASR:   o_result = $signed(i_op1) >>> i_op2[4:0];
	AND:   o_result = i_op1 & i_op2;
	OR:    o_result = i_op1 | i_op2;
	XOR:   o_result = i_op1 ^ i_op2;
	BIC:   o_result = i_op1 & ~(32'b1 << i_op2[4:0]);
	BST:   o_result = i_op1 | (32'b1 << i_op2[4:0]);
	COPYA: o_result = i_op1;
	COPYB: o_result = i_op2;
	CMP: begin
		o_result = diff[31:0];
		o_c = ~diff[32]; // carry set means no borrow.
		o_o = (i_op1[31] ^ i_op2[31]) & (diff[31] == i_op2[31]);
		o_n = diff[31];
	end
	MOVHI: o_result = i_op1 | {16'b0, i_op2[15:0]}; // upper half arrives in op1.
	GCR:   o_result = i_cr_val;
	SWI:   o_result = i_vector_base + 32'(SWI_OFFSET);
	RFE:   o_result = i_fault_addr; // return address.
	default: o_result = 32'b0;
	endcase
end

//////////////////////////////
// the decoder must never hand over an encoding beyond RFE.
always_comb begin
	if (!$isunknown(i_opc))
		a_opc_defined: assert (i_opc <= RFE)
			else $error("exec_alu: undefined opcode %0h", i_opc);
end

endmodule

`default_nettype wire

// File: logic/branch_eval.sv
`default_nettype none

module branch_eval import exec_pkg::*; (
	input  branch_cc_t i_cc,
	input  logic       i_c,
	input  logic       i_z,
	input  logic       i_n,
	input  logic       i_o,
	output logic       o_met
);

logic sign_ok; // signed greater-or-equal, n matches o.

assign sign_ok = (i_n == i_o);

always_comb begin
	case (i_cc)
	NE:   o_met = !i_z;
	EQ:   o_met = i_z;
	GT:   o_met = i_c && !i_z; // unsigned.
	LT:   o_met = !i_c;
	GTS:  o_met = !i_z && sign_ok;
	LTS:  o_met = !sign_ok;
	B:    o_met = 1'b1;
	GTE:  o_met = i_c;
	GTES: o_met = sign_ok;
	LTE:  o_met = !i_c || i_z;
	LTES: o_met = !sign_ok || i_z;
	default: o_met = 1'b0;
	endcase
end

endmodule

`default_nettype wire

// File: logic/control_regs.sv
`default_nettype none

module control_regs import exec_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        i_valid,
	input  logic        i_update_flags,
	input  logic        i_update_carry,
	input  logic        i_alu_c,
	input  logic        i_alu_z,
	input  logic        i_alu_n,
	input  logic        i_alu_o,
	input  logic        i_write_cr,
	input  cr_idx_t     i_cr_sel,
	input  logic [31:0] i_cr_wr_val,
	input  logic        i_swi,
	input  logic        i_rfe,
	input  logic        i_exc_start,
	input  logic [31:0] i_exc_pc,
	input  cr_idx_t     i_dbg_sel,
	input  logic [31:0] i_dbg_wr_val,
	input  logic        i_dbg_wr_en,
	output logic [31:0] o_dbg_val,
	output logic [31:0] o_cr_val,
	output logic [31:0] o_vector_base,
	output logic [31:0] o_fault_addr,
	output logic        o_c,
	output logic        o_z,
	output logic        o_n,
	output logic        o_o,
	output logic        o_irqs_enabled,
	output logic        o_user_mode
);

logic [25:0]      vbase_q; // vector base above the 64-byte alignment.
logic [PSR_W-1:0] psr_q;
logic [PSR_W-1:0] saved_psr_q;
logic [31:0]      fault_q;
logic             exc_save;
logic             dbg_psr;

assign exc_save = i_valid && (i_swi || i_exc_start);
assign dbg_psr = i_dbg_wr_en && i_dbg_sel == CR_PSR;

function automatic logic [31:0] cr_read(input cr_idx_t sel);
	case (sel)
	CR_VBASE:     cr_read = {vbase_q, 6'b0};
	CR_PSR:       cr_read = 32'(psr_q);
	CR_SAVED_PSR: cr_read = 32'(saved_psr_q);
	CR_FAULT:     cr_read = fault_q;
	default:      cr_read = 32'b0;
	endcase
endfunction

assign o_dbg_val = cr_read(i_dbg_sel);
assign o_cr_val = cr_read(i_cr_sel);
assign o_vector_base = {vbase_q, 6'b0};
assign o_fault_addr = fault_q;

//////////////////////////////
// debug writes first, then exception save, rfe, write_cr, flags.
always_ff @(posedge clk) begin
	if (rst)
		vbase_q <= 26'b0;
	else if (i_dbg_wr_en && i_dbg_sel == CR_VBASE)
		vbase_q <= i_dbg_wr_val[31:6];
	else if (i_valid && i_write_cr && i_cr_sel == CR_VBASE)
		vbase_q <= i_cr_wr_val[31:6];
end

always_ff @(posedge clk) begin
	if (rst) begin
		psr_q <= '0;
	end else if (dbg_psr) begin
		psr_q <= i_dbg_wr_val[PSR_W-1:0];
	end else if (exc_save) begin
		psr_q[PSR_IRQ] <= 1'b0; // handler starts privileged, irqs off.
		psr_q[PSR_USER] <= 1'b0;
	end else if (i_valid && i_rfe) begin
		psr_q <= saved_psr_q;
	end else if (i_valid && i_write_cr && i_cr_sel == CR_PSR) begin
		psr_q <= i_cr_wr_val[PSR_W-1:0];
	end else if (i_valid) begin
		if (i_update_flags) begin
			psr_q[PSR_Z] <= i_alu_z;
			psr_q[PSR_N] <= i_alu_n;
			psr_q[PSR_O] <= i_alu_o;
		end
		if (i_update_carry)
			psr_q[PSR_C] <= i_alu_c;
	end
end

always_ff @(posedge clk) begin
	if (rst)
		saved_psr_q <= '0;
	else if (i_dbg_wr_en && i_dbg_sel == CR_SAVED_PSR)
		saved_psr_q <= i_dbg_wr_val[PSR_W-1:0];
	else if (exc_save)
		saved_psr_q <= psr_q;
	else if (i_valid && i_write_cr && i_cr_sel == CR_SAVED_PSR)
		saved_psr_q <= i_cr_wr_val[PSR_W-1:0];
end

always_ff @(posedge clk) begin
	if (rst)
		fault_q <= 32'b0;
	else if (i_dbg_wr_en && i_dbg_sel == CR_FAULT)
		fault_q <= i_dbg_wr_val;
	else if (exc_save)
		fault_q <= i_exc_pc;
	else if (i_valid && i_write_cr && i_cr_sel == CR_FAULT)
		fault_q <= i_cr_wr_val;
end

assign o_c = psr_q[PSR_C];
assign o_z = psr_q[PSR_Z];
assign o_n = psr_q[PSR_N];
assign o_o = psr_q[PSR_O];
assign o_irqs_enabled = psr_q[PSR_IRQ];
assign o_user_mode = psr_q[PSR_USER];

// decode guarantees a single instruction is never both swi and rfe.
a_swi_rfe_excl: assert property (@(posedge clk) disable iff (rst) !(i_swi && i_rfe));

endmodule

`default_nettype wire

// File: logic/exec_stage.sv
`default_nettype none

module exec_stage import exec_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         i_valid,
	input  logic [31:0]  i_ra,
	input  logic [31:0]  i_rb,
	input  logic [31:0]  i_imm32,
	input  logic [31:0]  i_pc_plus_4,
	input  logic [3:0]   i_rd_sel,
	input  logic         i_update_rd,
	input  logic         i_op1_ra,
	input  logic         i_op1_rb,
	input  logic         i_op2_rb,
	input  alu_opc_t     i_alu_opc,
	input  branch_cc_t   i_branch_cc,
	input  instr_class_t i_class,
	input  logic         i_is_call,
	input  logic         i_is_swi,
	input  logic         i_is_rfe,
	input  logic         i_exc_start,
	input  logic         i_update_flags,
	input  logic         i_update_carry,
	input  logic         i_write_cr,
	input  logic         i_mem_load,
	input  logic         i_mem_store,
	input  cr_idx_t      i_cr_sel,
	input  cr_idx_t      i_dbg_sel,
	input  logic [31:0]  i_dbg_wr_val,
	input  logic         i_dbg_wr_en,
	output logic         o_valid,
	output logic [31:0]  o_alu_out,
	output logic [31:0]  o_wr_val,
	output logic         o_wr_result,
	output logic [3:0]   o_rd_sel,
	output logic         o_branch_taken,
	output logic         o_stall_clear,
	output logic [31:0]  o_mar,
	output logic [31:0]  o_mdr,
	output logic         o_mem_load,
	output logic         o_mem_store,
	output logic [31:0]  o_vector_base,
	output logic [31:0]  o_dbg_val,
	output logic         o_irqs_enabled,
	output logic         o_user_mode
);

logic [31:0] op1;
logic [31:0] op2;
logic [31:0] alu_result;
logic        alu_c;
logic        alu_z;
logic        alu_n;
logic        alu_o;
logic [31:0] cr_val;
logic [31:0] fault_addr;
logic        c_flag;
logic        z_flag;
logic        n_flag;
logic        o_flag;
logic        cond_met;

assign op1 = i_op1_ra ? i_ra : i_op1_rb ? i_rb : i_pc_plus_4;
assign op2 = i_op2_rb ? i_rb : i_imm32;

exec_alu u_alu (
	.i_op1         (op1),
	.i_op2         (op2),
	.i_opc         (i_alu_opc),
	.i_carry_in    (c_flag),
	.i_cr_val      (cr_val),
	.i_vector_base (o_vector_base),
	.i_fault_addr  (fault_addr),
	.o_result      (alu_result),
	.o_c           (alu_c),
	.o_z           (alu_z),
	.o_n           (alu_n),
	.o_o           (alu_o)
);

branch_eval u_branch (
	.i_cc  (i_branch_cc),
	.i_c   (c_flag),
	.i_z   (z_flag),
	.i_n   (n_flag),
	.i_o   (o_flag),
	.o_met (cond_met)
);

// swi saves pc_plus_4 so that rfe resumes after the trap.
control_regs u_cregs (
	.clk            (clk),
	.rst            (rst),
	.i_valid        (i_valid),
	.i_update_flags (i_update_flags),
	.i_update_carry (i_update_carry),
	.i_alu_c        (alu_c),
	.i_alu_z        (alu_z),
	.i_alu_n        (alu_n),
	.i_alu_o        (alu_o),
	.i_write_cr     (i_write_cr),
	.i_cr_sel       (i_cr_sel),
	.i_cr_wr_val    (i_ra),
	.i_swi          (i_is_swi),
	.i_rfe          (i_is_rfe),
	.i_exc_start    (i_exc_start),
	.i_exc_pc       (i_pc_plus_4),
	.i_dbg_sel      (i_dbg_sel),
	.i_dbg_wr_val   (i_dbg_wr_val),
	.i_dbg_wr_en    (i_dbg_wr_en),
	.o_dbg_val      (o_dbg_val),
	.o_cr_val       (cr_val),
	.o_vector_base  (o_vector_base),
	.o_fault_addr   (fault_addr),
	.o_c            (c_flag),
	.o_z            (z_flag),
	.o_n            (n_flag),
	.o_o            (o_flag),
	.o_irqs_enabled (o_irqs_enabled),
	.o_user_mode    (o_user_mode)
);

//////////////////////////////
// strobes drop on idle cycles; payload holds its last value.
always_ff @(posedge clk) begin
	if (rst) begin
		o_valid <= 1'b0;
		o_wr_result <= 1'b0;
		o_branch_taken <= 1'b0;
		o_stall_clear <= 1'b0;
		o_mem_load <= 1'b0;
		o_mem_store <= 1'b0;
	end else begin
		o_valid <= i_valid;
		o_wr_result <= i_valid && i_update_rd;
		o_branch_taken <= i_valid &&
			((i_class == BRANCH && cond_met) || i_is_swi || i_is_rfe);
		o_stall_clear <= i_valid &&
			(i_class == BRANCH || i_write_cr || i_alu_opc == GCR);
		o_mem_load <= i_valid && i_mem_load;
		o_mem_store <= i_valid && i_mem_store;
	end
end

always_ff @(posedge clk) begin
	if (rst) begin
		o_alu_out <= 32'b0;
		o_wr_val <= 32'b0;
		o_rd_sel <= 4'b0;
		o_mar <= 32'b0;
		o_mdr <= 32'b0;
	end else if (i_valid) begin
		o_alu_out <= alu_result;
		o_rd_sel <= i_rd_sel;
		o_wr_val <= i_is_call ? i_pc_plus_4 : // link address.
			i_mem_store ? op2 : alu_result;
		if (i_mem_load || i_mem_store) begin
			o_mar <= alu_result;
			o_mdr <= i_rb;
		end
	end
end

endmodule

`default_nettype wire

// File: verif/exec_clk_gen.sv
`default_nettype none

module exec_clk_gen (
	output logic clk,
	output logic rst
);

timeunit 1ns;
timeprecision 100ps;

initial begin
	clk = 1'b0;
	forever #2 clk = ~clk; // 4 ns period.
end

// reset is released with the same 1 ns offset as the stimulus.
initial begin
	rst = 1'b1;
	repeat (5) @(posedge clk);
	#1 rst = 1'b0;
end

endmodule

`default_nettype wire

// File: verif/exec_tb.sv
`default_nettype none

module exec_tb import exec_pkg::*; ();

timeunit 1ns;
timeprecision 100ps;

localparam int CLK_PERIOD = 4;
localparam int N_RAND = 200;
localparam int N_CMP = 8;
localparam int N_MEM = 40;
localparam int N_TOTAL = N_RAND + N_CMP * 17 + 16 + 6 + N_MEM;

logic         clk;
logic         rst;
logic         i_valid;
logic [31:0]  i_ra, i_rb, i_imm32, i_pc_plus_4;
logic [3:0]   i_rd_sel;
logic         i_update_rd, i_op1_ra, i_op1_rb, i_op2_rb;
alu_opc_t     i_alu_opc;
branch_cc_t   i_branch_cc;
instr_class_t i_class;
logic         i_is_call, i_is_swi, i_is_rfe, i_exc_start;
logic         i_update_flags, i_update_carry, i_write_cr, i_mem_load, i_mem_store;
cr_idx_t      i_cr_sel, i_dbg_sel;
logic [31:0]  i_dbg_wr_val;
logic         i_dbg_wr_en;
logic         o_valid, o_wr_result, o_branch_taken, o_stall_clear;
logic         o_mem_load, o_mem_store, o_irqs_enabled, o_user_mode;
logic [31:0]  o_alu_out, o_wr_val, o_mar, o_mdr, o_vector_base, o_dbg_val;
logic [3:0]   o_rd_sel;

// model of the stage state.
logic [31:0]  m_vbase = 32'b0;
logic [5:0]   m_psr = 6'b0;
logic [5:0]   m_saved = 6'b0;
logic [31:0]  m_fault = 32'b0;
logic [31:0]  last_alu = 32'b0, last_wr = 32'b0, last_mar = 32'b0, last_mdr = 32'b0;
logic [3:0]   last_rd = 4'b0;

// one entry per driven cycle.
logic [11:0]  q_bits[$];
logic [31:0]  q_alu[$], q_wr[$], q_mar[$], q_mdr[$], q_dbg[$], q_vbase[$];
logic [11:0]  prev_bits;
logic [31:0]  prev_alu, prev_wr, prev_mar, prev_mdr;
logic         have_prev = 1'b0;

exec_clk_gen u_clk_gen (.clk(clk), .rst(rst));

exec_stage i_exec_stage (.*);

//////////////////////////////
// reference model.
function automatic logic [31:0] cr_model(input cr_idx_t sel);
	case (sel)
	CR_VBASE:     return m_vbase;
	CR_PSR:       return {26'b0, m_psr};
	CR_SAVED_PSR: return {26'b0, m_saved};
	CR_FAULT:     return m_fault;
	default:      return 32'b0;
	endcase
endfunction

// returns {overflow, negative, carry, result}.
function automatic logic [34:0] alu_ref(input alu_opc_t opc, input logic [31:0] a,
		input logic [31:0] b, input logic cin);
	logic [32:0] wide;
	logic [31:0] r;
	logic        n;
	logic        ov;
	wide = 33'b0;
	n = 1'b0;
	ov = 1'b0;
	case (opc)
	ADD:   wide = {1'b0, a} + {1'b0, b};
	ADDC:  wide = {1'b0, a} + {1'b0, b} + {32'b0, cin};
	SUB:   wide = {1'b0, a} - {1'b0, b};
	SUBC:  wide = {1'b0, a} - {1'b0, b} - {32'b0, cin};
	LSL:   wide = {1'b0, a} << b[4:0];
	LSR:   wide[31:0] = a >> b[4:0];
	ASR:   wide[31:0] = $signed(a) >>> b[4:0];
	AND:   wide[31:0] = a & b;
	OR:    wide[31:0] = a | b;
	XOR:   wide[31:0] = a ^ b;
	BIC:   wide[31:0] = a & ~(32'b1 << b[4:0]);
	BST:   wide[31:0] = a | (32'b1 << b[4:0]);
	COPYA: wide[31:0] = a;
	COPYB: wide[31:0] = b;
	CMP: begin
		r = a - b;
		wide = {a >= b, r}; // carry means no borrow.
		n = r[31];
		ov = (a[31] != b[31]) && (r[31] != a[31]);
	end
	MOVHI: wide[31:0] = a | {16'b0, b[15:0]};
	GCR:   wide[31:0] = cr_model(i_cr_sel);
	SWI:   wide[31:0] = m_vbase + 32'(SWI_OFFSET);
	RFE:   wide[31:0] = m_fault;
	default: wide = 33'b0;
	endcase
	return {ov, n, wide};
endfunction

function automatic logic branch_ref(input branch_cc_t cc, input logic [5:0] psr);
	logic c;
	logic z;
	logic ge;
	c = psr[PSR_C];
	z = psr[PSR_Z];
	ge = (psr[PSR_N] == psr[PSR_O]); // signed a >= b.
	case (cc)
	NE:   return !z;
	EQ:   return z;
	GT:   return c && !z;
	LT:   return !c;
	GTS:  return ge && !z;
	LTS:  return !ge;
	B:    return 1'b1;
	GTE:  return c;
	GTES: return ge;
	LTE:  return !c || z;
	LTES: return !ge || z;
	default: return 1'b0;
	endcase
endfunction

function automatic logic [31:0] wr_val_ref(input logic call, input logic store,
		input logic [31:0] pc4, input logic [31:0] b2, input logic [31:0] alu);
	return call ? pc4 : (store ? b2 : alu);
endfunction

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp) begin
		$display("mismatch %s: got %h expected %h", name, got, exp);
		$display("TESTS FAILED");
		$fatal(1, "stopping at the first mismatch");
	end
endtask

//////////////////////////////
// stimulus helpers.
task automatic set_defaults();
	i_valid = 1'b1;
	i_ra = $urandom();
	i_rb = $urandom();
	i_imm32 = $urandom();
	i_pc_plus_4 = $urandom();
	i_rd_sel = 4'($urandom_range(15));
	i_update_rd = 1'b1;
	i_op1_ra = 1'b1;
	i_op1_rb = 1'b0;
	i_op2_rb = 1'b1;
	i_alu_opc = ADD;
	i_branch_cc = B;
	i_class = ARITH;
	i_is_call = 1'b0;
	i_is_swi = 1'b0;
	i_is_rfe = 1'b0;
	i_exc_start = 1'b0;
	i_update_flags = 1'b0;
	i_update_carry = 1'b0;
	i_write_cr = 1'b0;
	i_mem_load = 1'b0;
	i_mem_store = 1'b0;
	i_cr_sel = CR_VBASE;
	i_dbg_sel = cr_idx_t'(3'($urandom_range(7))); // also reads the unused indices.
	i_dbg_wr_val = $urandom();
	i_dbg_wr_en = 1'b0;
endtask

task automatic next_slot();
	@(posedge clk);
	#1;
	set_defaults();
endtask

// records what the dut must show, then steps the model past the edge.
task automatic commit();
	logic [31:0] a;
	logic [31:0] b2;
	logic [34:0] res;
	logic        taken;
	logic        stall;
	logic        exc;
	logic [5:0]  psr_old;
	logic [5:0]  saved_old;
	a = i_op1_ra ? i_ra : (i_op1_rb ? i_rb : i_pc_plus_4);
	b2 = i_op2_rb ? i_rb : i_imm32;
	res = alu_ref(i_alu_opc, a, b2, m_psr[PSR_C]);
	taken = i_valid && ((i_class == BRANCH && branch_ref(i_branch_cc, m_psr))
		|| i_is_swi || i_is_rfe);
	stall = i_valid && (i_class == BRANCH || i_write_cr || i_alu_opc == GCR);
	if (i_valid) begin
		last_alu = res[31:0];
		last_wr = wr_val_ref(i_is_call, i_mem_store, i_pc_plus_4, b2, res[31:0]);
		last_rd = i_rd_sel;
		if (i_mem_load || i_mem_store) begin
			last_mar = res[31:0];
			last_mdr = i_rb;
		end
	end
	q_bits.push_back({i_valid, i_valid && i_update_rd, last_rd, taken, stall,
		i_valid && i_mem_load, i_valid && i_mem_store, m_psr[PSR_IRQ], m_psr[PSR_USER]});
	q_alu.push_back(last_alu);
	q_wr.push_back(last_wr);
	q_mar.push_back(last_mar);
	q_mdr.push_back(last_mdr);
	q_dbg.push_back(cr_model(i_dbg_sel));
	q_vbase.push_back(m_vbase);

	psr_old = m_psr;
	saved_old = m_saved;
	exc = i_valid && (i_is_swi || i_exc_start);
	if (i_dbg_wr_en && i_dbg_sel == CR_VBASE)
		m_vbase = {i_dbg_wr_val[31:6], 6'b0};
	else if (i_valid && i_write_cr && i_cr_sel == CR_VBASE)
		m_vbase = {i_ra[31:6], 6'b0};
	if (i_dbg_wr_en && i_dbg_sel == CR_SAVED_PSR)
		m_saved = i_dbg_wr_val[5:0];
	else if (exc)
		m_saved = psr_old;
	else if (i_valid && i_write_cr && i_cr_sel == CR_SAVED_PSR)
		m_saved = i_ra[5:0];
	if (i_dbg_wr_en && i_dbg_sel == CR_FAULT)
		m_fault = i_dbg_wr_val;
	else if (exc)
		m_fault = i_pc_plus_4;
	else if (i_valid && i_write_cr && i_cr_sel == CR_FAULT)
		m_fault = i_ra;
	if (i_dbg_wr_en && i_dbg_sel == CR_PSR) begin
		m_psr = i_dbg_wr_val[5:0];
	end else if (exc) begin
		m_psr[PSR_IRQ] = 1'b0;
		m_psr[PSR_USER] = 1'b0;
	end else if (i_valid && i_is_rfe) begin
		m_psr = saved_old;
	end else if (i_valid && i_write_cr && i_cr_sel == CR_PSR) begin
		m_psr = i_ra[5:0];
	end else if (i_valid) begin
		if (i_update_flags) begin
			m_psr[PSR_Z] = (a == b2);
			m_psr[PSR_N] = res[33];
			m_psr[PSR_O] = res[34];
		end
		if (i_update_carry)
			m_psr[PSR_C] = res[32];
	end
endtask

//////////////////////////////
// comb outputs checked in the same cycle, registered ones a cycle later.
always @(negedge clk) begin
	if (have_prev) begin
		check("o_valid", 32'(o_valid), 32'(prev_bits[11]));
		check("o_wr_result", 32'(o_wr_result), 32'(prev_bits[10]));
		check("o_rd_sel", 32'(o_rd_sel), 32'(prev_bits[9:6]));
		check("o_branch_taken", 32'(o_branch_taken), 32'(prev_bits[5]));
		check("o_stall_clear", 32'(o_stall_clear), 32'(prev_bits[4]));
		check("o_mem_load", 32'(o_mem_load), 32'(prev_bits[3]));
		check("o_mem_store", 32'(o_mem_store), 32'(prev_bits[2]));
		check("o_alu_out", o_alu_out, prev_alu);
		check("o_wr_val", o_wr_val, prev_wr);
		check("o_mar", o_mar, prev_mar);
		check("o_mdr", o_mdr, prev_mdr);
	end
	have_prev = 1'b0;
	if (q_bits.size() > 0) begin
		prev_bits = q_bits.pop_front();
		prev_alu = q_alu.pop_front();
		prev_wr = q_wr.pop_front();
		prev_mar = q_mar.pop_front();
		prev_mdr = q_mdr.pop_front();
		check("o_dbg_val", o_dbg_val, q_dbg.pop_front());
		check("o_vector_base", o_vector_base, q_vbase.pop_front());
		check("o_irqs_enabled", 32'(o_irqs_enabled), 32'(prev_bits[1]));
		check("o_user_mode", 32'(o_user_mode), 32'(prev_bits[0]));
		have_prev = 1'b1;
	end
end

initial begin
	#((N_TOTAL + 60) * CLK_PERIOD);
	$display("TESTS FAILED");
	$fatal(1, "watchdog expired before the tests completed");
end

initial begin
	void'($urandom(15));
	set_defaults();
	i_valid = 1'b0;
	@(negedge rst);

	// random alu traffic with idle cycles mixed in.
	for (int k = 0; k < N_RAND; k++) begin
		next_slot();
		i_valid = ($urandom_range(7) != 0);
		i_alu_opc = alu_opc_t'(5'($urandom_range(16))); // ADD through GCR.
		i_op1_ra = 1'($urandom_range(1));
		i_op1_rb = 1'($urandom_range(1));
		i_op2_rb = 1'($urandom_range(1));
		i_cr_sel = cr_idx_t'(3'($urandom_range(7)));
		i_update_flags = 1'($urandom_range(1));
		i_update_carry = 1'($urandom_range(1));
		commit();
	end

	// compare, then every condition code.
	for (int k = 0; k < N_CMP; k++) begin
		next_slot();
		i_alu_opc = CMP;
		if (k == 0)
			i_rb = i_ra;
		else if (k == 1)
			i_rb = i_ra ^ 32'h8000_0000;
		else if (k == 2)
			i_rb = i_ra + 1;
		i_update_flags = 1'b1;
		i_update_carry = 1'b1;
		commit();
		for (int cc = 0; cc < 16; cc++) begin
			next_slot();
			i_class = BRANCH;
			i_branch_cc = branch_cc_t'(4'(cc));
			i_update_rd = 1'b0;
			commit();
		end
	end

	// control register writes; the second half collides with a debug write.
	for (int k = 0; k < 8; k++) begin
		next_slot();
		i_valid = (k != 6);
		i_write_cr = 1'b1;
		i_cr_sel = cr_idx_t'(3'(k % 4));
		i_dbg_wr_en = (k >= 4);
		i_dbg_sel = cr_idx_t'(3'(k % 4));
		commit();
		next_slot();
		i_alu_opc = GCR;
		i_cr_sel = cr_idx_t'(3'(k % 4));
		i_dbg_sel = cr_idx_t'(3'(k % 4));
		commit();
	end

	// swi and rfe around user mode with irqs on.
	next_slot();
	i_valid = 1'b0;
	i_dbg_wr_en = 1'b1;
	i_dbg_sel = CR_PSR;
	i_dbg_wr_val = 32'h0000_003a;
	commit();
	next_slot();
	i_is_swi = 1'b1;
	i_alu_opc = SWI;
	commit();
	next_slot();
	i_update_flags = 1'b1;
	i_dbg_sel = CR_SAVED_PSR;
	commit();
	next_slot();
	i_is_rfe = 1'b1;
	i_alu_opc = RFE;
	commit();
	next_slot();
	i_exc_start = 1'b1;
	i_dbg_sel = CR_PSR; // status as restored by rfe.
	commit();
	next_slot();
	i_is_rfe = 1'b1;
	i_alu_opc = RFE;
	i_dbg_sel = CR_FAULT;
	commit();

	// loads, stores and calls.
	for (int k = 0; k < N_MEM; k++) begin
		next_slot();
		i_valid = ($urandom_range(3) != 0);
		i_class = MEM;
		i_op2_rb = 1'b0;
		i_mem_load = 1'($urandom_range(1));
		i_mem_store = !i_mem_load;
		i_update_rd = i_mem_load;
		if (k % 5 == 0) begin
			i_class = BRANCH;
			i_is_call = 1'b1;
			i_mem_load = 1'b0;
			i_mem_store = 1'b0;
			i_update_rd = 1'b1;
		end
		commit();
	end

	repeat (3) @(posedge clk);
	if (q_bits.size() == 0) begin
		$display("TESTS PASSED");
		$finish;
	end else begin
		$display("TESTS FAILED");
		$fatal(1, "expected responses were left unchecked");
	end
end

endmodule

`default_nettype wire

// File: list.f
logic/exec_pkg.sv
logic/exec_alu.sv
logic/branch_eval.sv
logic/control_regs.sv
logic/exec_stage.sv
verif/exec_clk_gen.sv
verif/exec_tb.sv

// File: Makefile
TOP = exec_tb

.PHONY: all build lint clean

all: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "TESTS PASSED" sim.log

build:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f list.f --top-module $(TOP) -Mdir obj_dir

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps \
		-f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
